/* hdl/isa_pkg.sv */
package isa_pkg;

  // --------------------------------------------------------------------------
  // architectural sizes
  // --------------------------------------------------------------------------
  localparam int unsigned XLEN       = 32;
  // program counter width
  localparam int unsigned VLEN       = 32;
  localparam int unsigned REG_ADDR_W = 5;
  // x0..x31
  localparam int unsigned NR_REGS    = 32;

  typedef logic [XLEN-1:0]       xlen_t;
  typedef logic [REG_ADDR_W-1:0] reg_addr_t;

  // operations the decoder can hand to the issue stage
  // csrrwi is the zimm form of csrrw
  typedef enum logic [3:0] {
    NOP, ADD, SUB, AND, OR, MUL, LW, SW, BEQ, JAL, CSRRW, CSRRWI
  } fu_op_t;

endpackage

/* hdl/issue_pkg.sv */
package issue_pkg;
  import isa_pkg::*;

  // scoreboard tag width
  localparam int unsigned TRANS_ID_W = 3;

  // --------------------------------------------------------------------------
  // functional units
  // --------------------------------------------------------------------------
  // none marks entries that need no unit at all
  typedef enum logic [2:0] {
    NONE, ALU, CTRL_FLOW, MULT, LOAD, STORE, CSR
  } fu_t;

  // --------------------------------------------------------------------------
  // decoded instruction from the scoreboard
  // --------------------------------------------------------------------------
  typedef struct packed {
    logic [VLEN-1:0]       pc;
    logic [TRANS_ID_W-1:0] trans_id;
    fu_t                   fu;
    fu_op_t                op;
    reg_addr_t             rs1;
    reg_addr_t             rs2;
    reg_addr_t             rd;
    // immediate value
    xlen_t                 result;
    logic                  use_imm;
    logic                  use_zimm;
    logic                  use_pc;
    logic                  is_compressed;
    // exception already raised upstream
    logic                  ex_valid;
  } issue_entry_t;

  // --------------------------------------------------------------------------
  // bundle handed to the execute stage
  // --------------------------------------------------------------------------
  typedef struct packed {
    fu_t                   fu;
    fu_op_t                op;
    xlen_t                 operand_a;
    xlen_t                 operand_b;
    xlen_t                 imm;
    logic [TRANS_ID_W-1:0] trans_id;
  } fu_data_t;

endpackage

/* hdl/issue_if.sv */
// two combinational read ports into the integer regfile
interface rf_read_if
  import isa_pkg::*;
();
  reg_addr_t raddr_a;
  reg_addr_t raddr_b;
  xlen_t     rdata_a;
  xlen_t     rdata_b;

  // operand logic asks, regfile answers in the same cycle
  modport client (output raddr_a, output raddr_b, input rdata_a, input rdata_b);
  modport server (input raddr_a, input raddr_b, output rdata_a, output rdata_b);
endinterface

// issue decision and unregistered operands towards the ID/EX register
interface opnd_if
  import isa_pkg::*;
  import issue_pkg::*;
();
  logic            fire;
  logic            ack;
  fu_data_t        data_n;
  logic [VLEN-1:0] pc;
  logic            is_compressed;
  fu_t             fu;
  // multiply valid currently held in the dispatch register
  logic            mult_pending;

  modport producer (
    output fire, output ack, output data_n, output pc, output is_compressed,
    output fu, input mult_pending
  );
  modport consumer (
    input fire, input ack, input data_n, input pc, input is_compressed,
    input fu, output mult_pending
  );
endinterface

/* hdl/int_regfile.sv */
module int_regfile
  import isa_pkg::*;
#(
  parameter int unsigned NR_COMMIT_PORTS = 2
) (
  input  logic                             clk_i,
  input  logic                             rst_ni,
  input  reg_addr_t [NR_COMMIT_PORTS-1:0]  waddr_i,
  input  xlen_t     [NR_COMMIT_PORTS-1:0]  wdata_i,
  input  logic      [NR_COMMIT_PORTS-1:0]  we_i,
  rf_read_if.server                        rd
);

  // x1..x31 only, x0 has no storage
  xlen_t regs_q [1:NR_REGS-1];

  // --------------------------------------------------------------------------
  // commit writes
  // --------------------------------------------------------------------------
  // ports walked low to high, so the last nonblocking write wins
  // and the higher commit port takes the register on a collision
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      for (int unsigned r = 1; r < NR_REGS; r++) begin
        regs_q[r] <= '0;
      end
    end else begin
      for (int unsigned k = 0; k < NR_COMMIT_PORTS; k++) begin
        // writes to x0 are dropped
        if (we_i[k] && (waddr_i[k] != '0)) begin
          regs_q[waddr_i[k]] <= wdata_i[k];
        end
      end
    end
  end

  // combinational reads, x0 hardwired to zero
  assign rd.rdata_a = (rd.raddr_a == '0) ? '0 : regs_q[rd.raddr_a];
  assign rd.rdata_b = (rd.raddr_b == '0) ? '0 : regs_q[rd.raddr_b];

  // highest commit port always lands, held in the file next cycle
  top_port_lands : assert property (@(posedge clk_i) disable iff (!rst_ni)
    (we_i[NR_COMMIT_PORTS-1] && (waddr_i[NR_COMMIT_PORTS-1] != '0))
    |=> (regs_q[$past(waddr_i[NR_COMMIT_PORTS-1])] == $past(wdata_i[NR_COMMIT_PORTS-1])))
    else $error("commit on the highest port was lost");

endmodule

/* hdl/issue_operands.sv */
module issue_operands
  import isa_pkg::*;
  import issue_pkg::*;
#(
  parameter int unsigned NR_COMMIT_PORTS = 2
) (
  input  issue_entry_t                     issue_instr_i,
  input  logic                             issue_valid_i,
  // forwarded values from the scoreboard
  input  xlen_t                            rs1_i,
  input  xlen_t                            rs2_i,
  input  logic                             rs1_valid_i,
  input  logic                             rs2_valid_i,
  input  fu_t       [NR_REGS-1:0]          rd_clobber_i,
  input  logic                             alu_ready_i,
  input  logic                             lsu_ready_i,
  // commit ports, only for the waw bypass
  input  reg_addr_t [NR_COMMIT_PORTS-1:0]  waddr_i,
  input  logic      [NR_COMMIT_PORTS-1:0]  we_i,
  output reg_addr_t                        rs1_o,
  output reg_addr_t                        rs2_o,
  output logic                             issue_ack_o,
  output logic                             stall_issue_o,
  rf_read_if.client                        rf,
  opnd_if.producer                         op
);

  logic  stall;
  logic  fu_busy;
  logic  forward_rs1;
  logic  forward_rs2;
  logic  ack;
  xlen_t operand_a;
  xlen_t operand_b;

  // scoreboard lookup and regfile read use the same indices
  assign rs1_o      = issue_instr_i.rs1;
  assign rs2_o      = issue_instr_i.rs2;
  assign rf.raddr_a = issue_instr_i.rs1;
  assign rf.raddr_b = issue_instr_i.rs2;

  // --------------------------------------------------------------------------
  // unit readiness
  // --------------------------------------------------------------------------
  always_comb begin : unit_busy
    unique case (issue_instr_i.fu)
      // mult shares the fixed latency path with the alu
      ALU, CTRL_FLOW, MULT, CSR: fu_busy = ~alu_ready_i;
      LOAD, STORE:               fu_busy = ~lsu_ready_i;
      default:                   fu_busy = 1'b0;
    endcase
  end

  // --------------------------------------------------------------------------
  // source availability
  // --------------------------------------------------------------------------
  always_comb begin : source_check
    stall       = 1'b0;
    forward_rs1 = 1'b0;
    forward_rs2 = 1'b0;
    // zimm is an immediate, nothing to wait for on rs1
    if (!issue_instr_i.use_zimm && (rd_clobber_i[issue_instr_i.rs1] != NONE)) begin
      // csr results can only be picked up from the regfile
      if (rs1_valid_i && (rd_clobber_i[issue_instr_i.rs1] != CSR)) begin
        forward_rs1 = 1'b1;
      end else begin
        stall = 1'b1;
      end
    end
    if (rd_clobber_i[issue_instr_i.rs2] != NONE) begin
      if (rs2_valid_i && (rd_clobber_i[issue_instr_i.rs2] != CSR)) begin
        forward_rs2 = 1'b1;
      end else begin
        stall = 1'b1;
      end
    end
  end

  // --------------------------------------------------------------------------
  // issue decision
  // --------------------------------------------------------------------------
  always_comb begin : issue_decision
    ack = 1'b0;
    if (issue_valid_i) begin
      if (!stall && !fu_busy) begin
        // waw check, rd free or retired by commit in this cycle
        if (rd_clobber_i[issue_instr_i.rd] == NONE) begin
          ack = 1'b1;
        end
        for (int unsigned k = 0; k < NR_COMMIT_PORTS; k++) begin
          if (we_i[k] && (waddr_i[k] == issue_instr_i.rd)) begin
            ack = 1'b1;
          end
        end
      end
      // exceptions and unit-less entries just pass through
      if (issue_instr_i.ex_valid) begin
        ack = 1'b1;
      end
      if (issue_instr_i.fu == NONE) begin
        ack = 1'b1;
      end
    end
    // pending multiply owns the shared result bus next cycle
    if (op.mult_pending && (issue_instr_i.fu inside {ALU, CTRL_FLOW, CSR})) begin
      ack = 1'b0;
    end
  end

  // --------------------------------------------------------------------------
  // operand select
  // --------------------------------------------------------------------------
  always_comb begin : operand_select
    operand_a = rf.rdata_a;
    operand_b = rf.rdata_b;
    if (forward_rs1) begin
      operand_a = rs1_i;
    end
    if (forward_rs2) begin
      operand_b = rs2_i;
    end
    if (issue_instr_i.use_pc) begin
      operand_a = xlen_t'(issue_instr_i.pc);
    end
    // zimm sits in the rs1 field, zero extended
    if (issue_instr_i.use_zimm) begin
      operand_a = xlen_t'(issue_instr_i.rs1);
    end
    // store and branch keep rs2 in b, their immediate travels in imm
    if (issue_instr_i.use_imm && (issue_instr_i.fu != STORE) &&
        (issue_instr_i.fu != CTRL_FLOW)) begin
      operand_b = issue_instr_i.result;
    end
  end

  always_comb begin : bundle_out
    op.data_n.fu        = issue_instr_i.fu;
    op.data_n.op        = issue_instr_i.op;
    op.data_n.operand_a = operand_a;
    op.data_n.operand_b = operand_b;
    op.data_n.imm       = issue_instr_i.result;
    op.data_n.trans_id  = issue_instr_i.trans_id;
  end

  assign op.pc            = issue_instr_i.pc;
  assign op.is_compressed = issue_instr_i.is_compressed;
  assign op.fu            = issue_instr_i.fu;
  assign op.ack           = ack;
  // only real work reaches a unit
  assign op.fire          = issue_valid_i && ack && !issue_instr_i.ex_valid;
  assign issue_ack_o      = ack;
  assign stall_issue_o    = stall;

endmodule

/* hdl/fu_dispatch.sv */
module fu_dispatch
  import issue_pkg::*;
  import isa_pkg::*;
(
  input  logic     clk_i,
  input  logic     rst_ni,
  input  logic     flush_i,
  opnd_if.consumer op,
  output fu_data_t fu_data_o,
  output xlen_t    pc_o,
  output logic     is_compressed_o,
  output logic     alu_valid_o,
  output logic     branch_valid_o,
  output logic     mult_valid_o,
  output logic     lsu_valid_o,
  output logic     csr_valid_o
);

  logic alu_d;
  logic branch_d;
  logic mult_d;
  logic lsu_d;
  logic csr_d;

  // --------------------------------------------------------------------------
  // ID/EX register
  // --------------------------------------------------------------------------
  // loaded every cycle, the unit valids qualify it
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      fu_data_o       <= '{fu: NONE, op: NOP, operand_a: '0, operand_b: '0,
                           imm: '0, trans_id: '0};
      pc_o            <= '0;
      is_compressed_o <= 1'b0;
    end else begin
      fu_data_o       <= op.data_n;
      pc_o            <= xlen_t'(op.pc);
      is_compressed_o <= op.is_compressed;
    end
  end

  // unit select, one valid per fired entry
  always_comb begin : unit_decode
    alu_d    = 1'b0;
    branch_d = 1'b0;
    mult_d   = 1'b0;
    lsu_d    = 1'b0;
    csr_d    = 1'b0;
    // flush kills the pulse, the register content is don't care
    if (op.fire && !flush_i) begin
      unique case (op.fu)
        ALU:         alu_d    = 1'b1;
        CTRL_FLOW:   branch_d = 1'b1;
        MULT:        mult_d   = 1'b1;
        LOAD, STORE: lsu_d    = 1'b1;
        CSR:         csr_d    = 1'b1;
        default:     ;
      endcase
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      alu_valid_o    <= 1'b0;
      branch_valid_o <= 1'b0;
      mult_valid_o   <= 1'b0;
      lsu_valid_o    <= 1'b0;
      csr_valid_o    <= 1'b0;
    end else begin
      alu_valid_o    <= alu_d;
      branch_valid_o <= branch_d;
      mult_valid_o   <= mult_d;
      lsu_valid_o    <= lsu_d;
      csr_valid_o    <= csr_d;
    end
  end

  // back to the issue logic for the contention rule
  assign op.mult_pending = mult_valid_o;

  one_unit_valid : assert property (@(posedge clk_i) disable iff (!rst_ni)
    $onehot0({alu_valid_o, branch_valid_o, mult_valid_o, lsu_valid_o, csr_valid_o}))
    else $error("more than one unit valid");

  // no alu-path entry may be accepted behind a multiply in flight
  mult_blocks_alu : assert property (@(posedge clk_i) disable iff (!rst_ni)
    (op.mult_pending && (op.fu inside {ALU, CTRL_FLOW, CSR})) |-> !op.ack)
    else $error("entry acknowledged against pending multiply");

endmodule

/* hdl/issue_read_operands.sv */
module issue_read_operands
  import isa_pkg::*;
  import issue_pkg::*;
#(
  parameter int unsigned NR_COMMIT_PORTS = 2
) (
  input  logic                             clk_i,
  input  logic                             rst_ni,
  input  logic                             flush_i,
  // decoded entry
  input  issue_entry_t                     issue_instr_i,
  input  logic                             issue_valid_i,
  output logic                             issue_ack_o,
  output logic                             stall_issue_o,
  // scoreboard lookup and forwarding
  output reg_addr_t                        rs1_o,
  output reg_addr_t                        rs2_o,
  input  xlen_t                            rs1_i,
  input  xlen_t                            rs2_i,
  input  logic                             rs1_valid_i,
  input  logic                             rs2_valid_i,
  input  fu_t       [NR_REGS-1:0]          rd_clobber_i,
  // execute stage
  input  logic                             alu_ready_i,
  input  logic                             lsu_ready_i,
  output fu_data_t                         fu_data_o,
  output xlen_t                            pc_o,
  output logic                             is_compressed_o,
  output logic                             alu_valid_o,
  output logic                             branch_valid_o,
  output logic                             mult_valid_o,
  output logic                             lsu_valid_o,
  output logic                             csr_valid_o,
  // commit ports
  input  reg_addr_t [NR_COMMIT_PORTS-1:0]  waddr_i,
  input  xlen_t     [NR_COMMIT_PORTS-1:0]  wdata_i,
  input  logic      [NR_COMMIT_PORTS-1:0]  we_i
);

  rf_read_if rf_bus ();
  opnd_if    opnd_bus ();

  // architectural state, written by commit
  int_regfile #(
    .NR_COMMIT_PORTS(NR_COMMIT_PORTS)
  ) u_int_regfile (
    .clk_i  (clk_i),
    .rst_ni (rst_ni),
    .waddr_i(waddr_i),
    .wdata_i(wdata_i),
    .we_i   (we_i),
    .rd     (rf_bus.server)
  );

  // hazard checks and operand mux
  issue_operands #(
    .NR_COMMIT_PORTS(NR_COMMIT_PORTS)
  ) u_issue_operands (
    .issue_instr_i(issue_instr_i),
    .issue_valid_i(issue_valid_i),
    .rs1_i        (rs1_i),
    .rs2_i        (rs2_i),
    .rs1_valid_i  (rs1_valid_i),
    .rs2_valid_i  (rs2_valid_i),
    .rd_clobber_i (rd_clobber_i),
    .alu_ready_i  (alu_ready_i),
    .lsu_ready_i  (lsu_ready_i),
    .waddr_i      (waddr_i),
    .we_i         (we_i),
    .rs1_o        (rs1_o),
    .rs2_o        (rs2_o),
    .issue_ack_o  (issue_ack_o),
    .stall_issue_o(stall_issue_o),
    .rf           (rf_bus.client),
    .op           (opnd_bus.producer)
  );

  // ID/EX register and unit valids
  fu_dispatch u_fu_dispatch (
    .clk_i          (clk_i),
    .rst_ni         (rst_ni),
    .flush_i        (flush_i),
    .op             (opnd_bus.consumer),
    .fu_data_o      (fu_data_o),
    .pc_o           (pc_o),
    .is_compressed_o(is_compressed_o),
    .alu_valid_o    (alu_valid_o),
    .branch_valid_o (branch_valid_o),
    .mult_valid_o   (mult_valid_o),
    .lsu_valid_o    (lsu_valid_o),
    .csr_valid_o    (csr_valid_o)
  );

endmodule

/* verification/tb_issue_model.svh */
`ifndef TB_ISSUE_MODEL_SVH
`define TB_ISSUE_MODEL_SVH

// ----------------------------------------------------------------------------
// shadow of the architectural integer registers
// ----------------------------------------------------------------------------
// x0 is never written here, so it keeps reading zero
xlen_t shadow_rf [NR_REGS] = '{default: '0};

// commit ports applied low to high, the higher port lands last
function automatic void apply_commits();
  for (int k = 0; k < NR_COMMIT_PORTS; k++) begin
    if (we[k] && (waddr[k] != '0)) begin
      shadow_rf[waddr[k]] = wdata[k];
    end
  end
endfunction

// ----------------------------------------------------------------------------
// expected execute bundle for one acknowledged entry
// ----------------------------------------------------------------------------
function automatic fu_data_t ref_issue(
  input  issue_entry_t      e,
  input  fu_t [NR_REGS-1:0] clob,
  input  xlen_t             fwd_a,
  input  xlen_t             fwd_b,
  input  logic              fwd_a_ok,
  input  logic              fwd_b_ok,
  output fu_t               unit_exp
);
  fu_data_t d;
  logic     take_a;
  logic     take_b;
  // scoreboard value wins over the file, never for csr producers
  take_a = !e.use_zimm && (clob[e.rs1] != NONE) && fwd_a_ok && (clob[e.rs1] != CSR);
  take_b = (clob[e.rs2] != NONE) && fwd_b_ok && (clob[e.rs2] != CSR);
  d.fu        = e.fu;
  d.op        = e.op;
  d.trans_id  = e.trans_id;
  d.imm       = e.result;
  d.operand_a = take_a ? fwd_a : shadow_rf[e.rs1];
  d.operand_b = take_b ? fwd_b : shadow_rf[e.rs2];
  if (e.use_pc) begin
    d.operand_a = e.pc;
  end
  // zimm lives in the rs1 field
  if (e.use_zimm) begin
    d.operand_a = {{(XLEN-REG_ADDR_W){1'b0}}, e.rs1};
  end
  // stores and branches keep rs2, immediate only in imm
  if (e.use_imm && (e.fu != STORE) && (e.fu != CTRL_FLOW)) begin
    d.operand_b = e.result;
  end
  // an exception entry reaches no unit
  unit_exp = e.ex_valid ? NONE : e.fu;
  return d;
endfunction

// ----------------------------------------------------------------------------
// compare tasks
// ----------------------------------------------------------------------------
task automatic check_data(input fu_data_t got, input fu_data_t want);
  if (got !== want) begin
    report_failure($sformatf("ERR fu_data_o got %h exp %h", got, want));
  end
endtask

// valids as {alu, branch, mult, lsu, csr}
task automatic check_unit(input fu_t want_unit);
  logic [4:0] got;
  logic [4:0] want;
  got = {alu_valid, branch_valid, mult_valid, lsu_valid, csr_valid};
  case (want_unit)
    ALU:         want = 5'b10000;
    CTRL_FLOW:   want = 5'b01000;
    MULT:        want = 5'b00100;
    LOAD, STORE: want = 5'b00010;
    CSR:         want = 5'b00001;
    default:     want = 5'b00000;
  endcase
  if (got !== want) begin
    report_failure($sformatf("ERR unit valids {alu,branch,mult,lsu,csr} got %h exp %h",
                             got, want));
  end
endtask

task automatic check_bit(input string name, input logic got, input logic want);
  if (got !== want) begin
    report_failure($sformatf("ERR %s got %h exp %h", name, got, want));
  end
endtask

task automatic check_word(input string name, input xlen_t got, input xlen_t want);
  if (got !== want) begin
    report_failure($sformatf("ERR %s got %h exp %h", name, got, want));
  end
endtask

// scoreboard lookup indices
task automatic check_addr(input string name, input reg_addr_t got, input reg_addr_t want);
  if (got !== want) begin
    report_failure($sformatf("ERR %s got %h exp %h", name, got, want));
  end
endtask

`endif

/* verification/tb_issue_read_operands.sv */
module tb_issue_read_operands
  import isa_pkg::*;
  import issue_pkg::*;
();

  localparam int unsigned NR_COMMIT_PORTS = 2;
  // cycles any single wait may take
  localparam int unsigned ACK_TIMEOUT     = 20;

  logic                            clk_i;
  logic                            rst_ni;
  logic                            flush;
  issue_entry_t                    issue_instr;
  logic                            issue_valid;
  logic                            issue_ack;
  logic                            stall_issue;
  reg_addr_t                       rs1_idx;
  reg_addr_t                       rs2_idx;
  xlen_t                           rs1_fwd;
  xlen_t                           rs2_fwd;
  logic                            rs1_vld;
  logic                            rs2_vld;
  fu_t       [NR_REGS-1:0]         rd_clobber;
  logic                            alu_ready;
  logic                            lsu_ready;
  fu_data_t                        fu_data;
  xlen_t                           pc_out;
  logic                            is_compressed;
  logic                            alu_valid;
  logic                            branch_valid;
  logic                            mult_valid;
  logic                            lsu_valid;
  logic                            csr_valid;
  reg_addr_t [NR_COMMIT_PORTS-1:0] waddr;
  xlen_t     [NR_COMMIT_PORTS-1:0] wdata;
  logic      [NR_COMMIT_PORTS-1:0] we;
  integer                          seed = 32'he690;

  task automatic report_failure(input string what);
    $display("%s", what);
    $display("Checks failed");
    $fatal(1);
  endtask

  `include "tb_issue_model.svh"

  issue_read_operands #(
    .NR_COMMIT_PORTS(NR_COMMIT_PORTS)
  ) u_issue_read_operands (
    .clk_i          (clk_i),
    .rst_ni         (rst_ni),
    .flush_i        (flush),
    .issue_instr_i  (issue_instr),
    .issue_valid_i  (issue_valid),
    .issue_ack_o    (issue_ack),
    .stall_issue_o  (stall_issue),
    .rs1_o          (rs1_idx),
    .rs2_o          (rs2_idx),
    .rs1_i          (rs1_fwd),
    .rs2_i          (rs2_fwd),
    .rs1_valid_i    (rs1_vld),
    .rs2_valid_i    (rs2_vld),
    .rd_clobber_i   (rd_clobber),
    .alu_ready_i    (alu_ready),
    .lsu_ready_i    (lsu_ready),
    .fu_data_o      (fu_data),
    .pc_o           (pc_out),
    .is_compressed_o(is_compressed),
    .alu_valid_o    (alu_valid),
    .branch_valid_o (branch_valid),
    .mult_valid_o   (mult_valid),
    .lsu_valid_o    (lsu_valid),
    .csr_valid_o    (csr_valid),
    .waddr_i        (waddr),
    .wdata_i        (wdata),
    .we_i           (we)
  );

  initial begin
    clk_i = 1'b0;
    forever #5 clk_i = ~clk_i;
  end

  // ----------------------------------------------------------------------------
  // stimulus helpers, all entered and left 1 unit after a rising edge
  // ----------------------------------------------------------------------------
  // random pc, tag and immediate, every flag cleared
  function automatic issue_entry_t make_entry(input fu_t fu_sel, input fu_op_t opc,
                                              input reg_addr_t s1, input reg_addr_t s2,
                                              input reg_addr_t d);
    issue_entry_t e;
    e          = '0;
    e.pc       = $random(seed);
    e.trans_id = TRANS_ID_W'($random(seed));
    e.result   = $random(seed);
    e.fu       = fu_sel;
    e.op       = opc;
    e.rs1      = s1;
    e.rs2      = s2;
    e.rd       = d;
    return e;
  endfunction

  task automatic clear_clobbers();
    for (int r = 0; r < NR_REGS; r++) begin
      rd_clobber[r] = NONE;
    end
  endtask

  // one cycle on both commit ports
  task automatic commit_regs(input reg_addr_t a0, input xlen_t d0, input logic e0,
                             input reg_addr_t a1, input xlen_t d1, input logic e1);
    waddr[0] = a0;
    wdata[0] = d0;
    we[0]    = e0;
    waddr[1] = a1;
    wdata[1] = d1;
    we[1]    = e1;
    @(posedge clk_i);
    #1;
    we = '0;
  endtask

  task automatic present(input issue_entry_t e);
    issue_instr = e;
    issue_valid = 1'b1;
  endtask

  // entry held while ack must stay low
  task automatic hold_blocked(input int n, input logic want_stall);
    repeat (n) begin
      @(negedge clk_i);
      check_bit("issue_ack_o", issue_ack, 1'b0);
      check_bit("stall_issue_o", stall_issue, want_stall);
      @(posedge clk_i);
      #1;
    end
  endtask

  task automatic wait_ack();
    logic seen;
    seen = 1'b0;
    for (int n = 0; (n < ACK_TIMEOUT) && !seen; n++) begin
      @(negedge clk_i);
      if (issue_ack) begin
        seen = 1'b1;
      end else begin
        @(posedge clk_i);
        #1;
      end
    end
    if (!seen) begin
      report_failure("timed out waiting for issue_ack_o");
    end
    @(posedge clk_i);
    #1;
    issue_valid = 1'b0;
  endtask

  task automatic issue_and_wait(input issue_entry_t e);
    present(e);
    wait_ack();
  endtask

  // back to back, must go in the cycle it is presented
  task automatic issue_immediate(input issue_entry_t e);
    present(e);
    @(negedge clk_i);
    check_bit("issue_ack_o", issue_ack, 1'b1);
    @(posedge clk_i);
    #1;
  endtask

  // ----------------------------------------------------------------------------
  // compare, mid cycle when inputs and registers are settled
  // ----------------------------------------------------------------------------
  initial begin : compare
    logic     due;
    fu_data_t due_data;
    fu_t      due_unit;
    xlen_t    due_pc;
    logic     due_c;
    due      = 1'b0;
    due_data = '0;
    due_unit = NONE;
    due_pc   = '0;
    due_c    = 1'b0;
    forever begin
      @(negedge clk_i);
      if (rst_ni) begin
        // no acknowledge last cycle means no valid now
        check_unit(due ? due_unit : NONE);
        if (due) begin
          check_data(fu_data, due_data);
          check_word("pc_o", pc_out, due_pc);
          check_bit("is_compressed_o", is_compressed, due_c);
        end
        // lookup indices follow the entry fields
        check_addr("rs1_o", rs1_idx, issue_instr.rs1);
        check_addr("rs2_o", rs2_idx, issue_instr.rs2);
        due = issue_valid && issue_ack;
        if (due) begin
          due_data = ref_issue(issue_instr, rd_clobber, rs1_fwd, rs2_fwd, rs1_vld, rs2_vld,
                               due_unit);
          if (flush) begin
            due_unit = NONE;
          end
          due_pc = issue_instr.pc;
          due_c  = issue_instr.is_compressed;
        end
        // reads this cycle saw the old file contents
        apply_commits();
      end
    end
  end

  // ----------------------------------------------------------------------------
  // test sequences
  // ----------------------------------------------------------------------------
  initial begin : stimulus
    issue_entry_t e;
    rst_ni      = 1'b0;
    flush       = 1'b0;
    issue_instr = '0;
    issue_valid = 1'b0;
    rs1_fwd     = '0;
    rs2_fwd     = '0;
    rs1_vld     = 1'b0;
    rs2_vld     = 1'b0;
    alu_ready   = 1'b1;
    lsu_ready   = 1'b1;
    waddr       = '0;
    wdata       = '0;
    we          = '0;
    clear_clobbers();
    repeat (8) @(posedge clk_i);
    #1;
    rst_ni = 1'b1;

    // reset contents of the ID/EX register
    @(negedge clk_i);
    check_data(fu_data, '{fu: NONE, op: NOP, operand_a: '0, operand_b: '0, imm: '0,
                          trans_id: '0});
    check_word("pc_o", pc_out, '0);
    @(posedge clk_i);
    #1;

    // commits on both ports, a port collision, a write to x0
    commit_regs(5'd5, $random(seed), 1'b1, 5'd6, $random(seed), 1'b1);
    commit_regs(5'd7, $random(seed), 1'b1, 5'd7, $random(seed), 1'b1);
    commit_regs(5'd0, $random(seed), 1'b1, 5'd9, $random(seed), 1'b1);
    // x9 read in the cycle right after its commit
    issue_and_wait(make_entry(ALU, OR, 5'd0, 5'd9, 5'd10));
    issue_and_wait(make_entry(ALU, ADD, 5'd5, 5'd6, 5'd8));
    issue_and_wait(make_entry(ALU, SUB, 5'd7, 5'd0, 5'd8));

    // forwarding, then a stall on each kind of unready source
    rd_clobber[5] = LOAD;
    rs1_vld       = 1'b1;
    rs1_fwd       = $random(seed);
    rs2_fwd       = $random(seed);
    issue_and_wait(make_entry(ALU, ADD, 5'd5, 5'd6, 5'd8));
    rd_clobber[6] = MULT;
    present(make_entry(ALU, AND, 5'd5, 5'd6, 5'd8));
    hold_blocked(3, 1'b1);
    rs2_vld = 1'b1;
    wait_ack();
    rd_clobber[6] = CSR;
    present(make_entry(ALU, AND, 5'd1, 5'd6, 5'd8));
    hold_blocked(3, 1'b1);
    rd_clobber[6] = NONE;
    wait_ack();
    clear_clobbers();
    rs1_vld = 1'b0;
    rs2_vld = 1'b0;

    // pc, zimm and immediate substitution
    e         = make_entry(ALU, ADD, 5'd5, 5'd6, 5'd11);
    e.use_pc  = 1'b1;
    e.use_imm = 1'b1;
    issue_and_wait(e);
    // rs1 clobber ignored for the zimm form
    rd_clobber[19] = LOAD;
    e              = make_entry(CSR, CSRRWI, 5'd19, 5'd0, 5'd12);
    e.use_zimm     = 1'b1;
    issue_and_wait(e);
    clear_clobbers();
    e         = make_entry(STORE, SW, 5'd5, 5'd6, 5'd0);
    e.use_imm = 1'b1;
    issue_and_wait(e);
    e               = make_entry(CTRL_FLOW, BEQ, 5'd5, 5'd6, 5'd0);
    e.use_imm       = 1'b1;
    e.is_compressed = 1'b1;
    issue_and_wait(e);

    // waw on rd, released by a same-cycle commit
    rd_clobber[9] = ALU;
    present(make_entry(ALU, ADD, 5'd5, 5'd6, 5'd9));
    hold_blocked(3, 1'b0);
    waddr[1] = 5'd9;
    wdata[1] = $random(seed);
    we[1]    = 1'b1;
    wait_ack();
    we = '0;
    clear_clobbers();
    // exception entry goes despite a stalled source
    rd_clobber[5] = MULT;
    e             = make_entry(ALU, ADD, 5'd5, 5'd6, 5'd8);
    e.ex_valid    = 1'b1;
    issue_and_wait(e);
    clear_clobbers();
    issue_and_wait(make_entry(NONE, NOP, 5'd0, 5'd0, 5'd0));

    // flush, ready back-pressure, multiply contention
    present(make_entry(ALU, ADD, 5'd5, 5'd6, 5'd8));
    flush = 1'b1;
    wait_ack();
    flush     = 1'b0;
    alu_ready = 1'b0;
    present(make_entry(MULT, MUL, 5'd5, 5'd6, 5'd8));
    hold_blocked(3, 1'b0);
    alu_ready = 1'b1;
    wait_ack();
    present(make_entry(ALU, SUB, 5'd6, 5'd5, 5'd10));
    @(negedge clk_i);
    check_bit("mult_valid_o", mult_valid, 1'b1);
    check_bit("issue_ack_o", issue_ack, 1'b0);
    @(posedge clk_i);
    #1;
    wait_ack();
    lsu_ready = 1'b0;
    present(make_entry(LOAD, LW, 5'd5, 5'd0, 5'd13));
    hold_blocked(3, 1'b0);
    lsu_ready = 1'b1;
    wait_ack();

    // back to back, one valid per cycle
    for (int i = 0; i < 3; i++) begin
      issue_immediate(make_entry(MULT, MUL, REG_ADDR_W'($random(seed)),
                                 REG_ADDR_W'($random(seed)), 5'd14));
    end
    for (int i = 0; i < 4; i++) begin
      issue_immediate(make_entry(LOAD, LW, REG_ADDR_W'($random(seed)), 5'd0, 5'd15));
      issue_immediate(make_entry(ALU, ADD, REG_ADDR_W'($random(seed)),
                                 REG_ADDR_W'($random(seed)), 5'd16));
    end
    issue_valid = 1'b0;
    repeat (3) @(posedge clk_i);
    #1;

    $display("All checks passed");
    $finish;
  end

endmodule

/* build.f */
+incdir+verification
hdl/isa_pkg.sv
hdl/issue_pkg.sv
hdl/issue_if.sv
hdl/int_regfile.sv
hdl/issue_operands.sv
hdl/fu_dispatch.sv
hdl/issue_read_operands.sv
verification/tb_issue_read_operands.sv

/* Makefile */
TOP := tb_issue_read_operands

.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only --timing -f build.f --top-module $(TOP)

# pass or fail is read from the log
sim:
	verilator --binary --timing --assert -f build.f --top-module $(TOP) -o $(TOP)
	./obj_dir/$(TOP) | tee sim.log
	grep -q "All checks passed" sim.log

clean:
	rm -rf obj_dir sim.log
